// File: ctrlQueue.f
hw/ctiqPkg.sv
hw/ctiqInitFsm.sv
hw/ctiqPointers.sv
hw/ctiqIdAssign.sv
hw/ctiqEntryRam.sv
hw/ctiqCommitBits.sv
hw/ctrlQueue.sv
tests/ctrlQueue_sva.sv
tests/ctrlQueueTb.sv

// File: hw/ctiqCommitBits.sv
`timescale 1ns/1ps

module ctiqCommitBits #(
  parameter int CommitWidth = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  ctiqPkg::ctiId_t                  commitPtr_i,
  input  logic [$clog2(CommitWidth+1)-1:0] commitCount_i,
  input  ctiqPkg::ctiId_t                  headPtr_i,
  input  logic                             clearHead_i,
  output logic                             headCommitted_o
);

  logic [ctiqPkg::QueueDepth-1:0] committed;
  ctiqPkg::ctiId_t                setAddr [0:CommitWidth-1];
  logic [CommitWidth-1:0]         setEn;

  // Commits arrive packed, so the first commitCount slots are taken
  always_comb
  begin
    for (int i = 0; i < CommitWidth; i++)
    begin
      setAddr[i] = commitPtr_i + ctiqPkg::ctiId_t'(i);
      setEn[i]   = (i < int'(commitCount_i));
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      committed <= '0;
    end
    else
    begin
      if (clearHead_i)
      begin
        committed[headPtr_i] <= 1'b0;
      end
      for (int i = 0; i < CommitWidth; i++)
      begin
        if (setEn[i])
        begin
          committed[setAddr[i]] <= 1'b1;
        end
      end
    end
  end

  assign headCommitted_o = committed[headPtr_i];

endmodule

// File: hw/ctiqEntryRam.sv
`timescale 1ns/1ps

module ctiqEntryRam #(
  parameter int FetchWidth = 4
) (
  input  logic                  clk,
  input  ctiqPkg::exeResolve_t  exeResolve_i,
  input  logic                  initWe_i,
  input  ctiqPkg::ctiId_t       initAddr_i,
  input  logic [FetchWidth-1:0] counterWe_i,
  input  ctiqPkg::ctiId_t       ctiId_i [0:FetchWidth-1],
  input  ctiqPkg::predCounter_t predCounter_i [0:FetchWidth-1],
  input  ctiqPkg::ctiId_t       headPtr_i,
  output ctiqPkg::ctiEntry_t    headEntry_o,
  output ctiqPkg::predCounter_t headCounter_o
);

  ctiqPkg::ctiEntry_t    dataMem    [0:ctiqPkg::QueueDepth-1];
  ctiqPkg::predCounter_t counterMem [0:ctiqPkg::QueueDepth-1];

  // Single write port, taken over by the clear walk after reset
  always_ff @(posedge clk)
  begin
    if (initWe_i)
    begin
      dataMem[initAddr_i] <= '0;
    end
    else if (exeResolve_i.valid)
    begin
      dataMem[exeResolve_i.ctiId] <= '{pc:       exeResolve_i.pc,
                                       npc:      exeResolve_i.npc,
                                       ctrlType: exeResolve_i.ctrlType,
                                       dir:      exeResolve_i.dir};
    end
  end

  // IDs within one bundle are distinct, so lane writes never collide
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < FetchWidth; i++)
    begin
      if (counterWe_i[i])
      begin
        counterMem[ctiId_i[i]] <= predCounter_i[i];
      end
    end
  end

  assign headEntry_o   = dataMem[headPtr_i];
  assign headCounter_o = counterMem[headPtr_i];

endmodule

// File: hw/ctiqIdAssign.sv
`timescale 1ns/1ps

module ctiqIdAssign #(
  parameter int FetchWidth = 4
) (
  input  logic [FetchWidth-1:0] ctrlVect_i,
  input  ctiqPkg::ctiId_t       tailPtr_i,
  output ctiqPkg::ctiId_t       ctiId_o [0:FetchWidth-1]
);

  // Running count of valid lanes below the current one
  always_comb
  begin
    ctiqPkg::ctiId_t offset;
    offset = '0;
    for (int i = 0; i < FetchWidth; i++)
    begin
      if (ctrlVect_i[i])
      begin
        ctiId_o[i] = tailPtr_i + offset;
        offset     = offset + 1'b1;
      end
      else
      begin
        ctiId_o[i] = '0;
      end
    end
  end

endmodule

// File: hw/ctiqInitFsm.sv
`timescale 1ns/1ps

module ctiqInitFsm (
  input  logic            clk,
  input  logic            reset,
  output logic            initWe_o,
  output ctiqPkg::ctiId_t initAddr_o,
  output logic            ramReady_o
);

  ctiqPkg::initState_t state;
  ctiqPkg::initState_t stateNext;
  ctiqPkg::ctiId_t     addr;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= ctiqPkg::InitStart;
      addr  <= '0;
    end
    else
    begin
      state <= stateNext;
      // Address only moves while entries are being cleared
      if (state == ctiqPkg::InitRun)
      begin
        addr <= addr + 1'b1;
      end
    end
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      ctiqPkg::InitStart: stateNext = ctiqPkg::InitRun;
      ctiqPkg::InitRun:
      begin
        if (addr == ctiqPkg::ctiId_t'(ctiqPkg::QueueDepth - 1))
        begin
          stateNext = ctiqPkg::InitDone;
        end
      end
      default: stateNext = ctiqPkg::InitDone;
    endcase
  end

  assign initWe_o   = (state == ctiqPkg::InitRun);
  assign initAddr_o = addr;
  assign ramReady_o = (state == ctiqPkg::InitDone);

endmodule

// File: hw/ctiqPkg.sv
package ctiqPkg;

  localparam int PcWidth    = 32;
  localparam int QueueDepth = 16;
  localparam int CtiIdWidth = $clog2(QueueDepth);
  // One extra bit so a full queue can be counted
  localparam int CountWidth = CtiIdWidth + 1;

  typedef logic [CtiIdWidth-1:0] ctiId_t;

  // Two-bit saturating counter as read from the predictor at fetch
  typedef logic [1:0] predCounter_t;

  typedef enum logic [1:0] {
    BrCond   = 2'd0,
    BrJump   = 2'd1,
    BrCall   = 2'd2,
    BrReturn = 2'd3
  } branchType_t;

  typedef enum logic [1:0] {
    InitStart = 2'd0,
    InitRun   = 2'd1,
    InitDone  = 2'd2
  } initState_t;

  // Execute write-back of a resolved control instruction
  typedef struct packed {
    logic [PcWidth-1:0] pc;
    logic [PcWidth-1:0] npc;
    branchType_t        ctrlType;
    logic               dir;
    ctiId_t             ctiId;
    logic               valid;
  } exeResolve_t;

  typedef struct packed {
    logic [PcWidth-1:0] pc;
    logic [PcWidth-1:0] npc;
    branchType_t        ctrlType;
    logic               dir;
  } ctiEntry_t;

  // Record drained to the predictor and BTB
  typedef struct packed {
    ctiEntry_t    entry;
    predCounter_t counter;
    logic         en;
  } predUpdate_t;

endpackage

// File: hw/ctiqPointers.sv
`timescale 1ns/1ps

module ctiqPointers #(
  parameter int FetchWidth  = 4,
  parameter int CommitWidth = 4
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [FetchWidth-1:0]              ctrlVect_i,
  input  logic                               fs1Ready_i,
  input  logic                               stall_i,
  input  logic                               recoverFlag_i,
  input  logic [CommitWidth-1:0]             commitCti_i,
  input  logic                               headCommitted_i,
  output ctiqPkg::ctiId_t                    tailPtr_o,
  output ctiqPkg::ctiId_t                    headPtr_o,
  output ctiqPkg::ctiId_t                    commitPtr_o,
  output logic [$clog2(CommitWidth+1)-1:0]   commitCount_o,
  output logic                               accept_o,
  output logic                               updateEn_o,
  output logic                               full_o
);

  localparam int LaneCntWidth = $clog2(FetchWidth + 1);

  ctiqPkg::ctiId_t                   tailPtr;
  ctiqPkg::ctiId_t                   headPtr;
  ctiqPkg::ctiId_t                   commitPtr;
  ctiqPkg::ctiId_t                   commitPtrNext;
  logic [ctiqPkg::CountWidth-1:0]    count;
  logic [ctiqPkg::CountWidth-1:0]    countNext;
  logic [ctiqPkg::CountWidth-1:0]    countRecover;
  logic [ctiqPkg::CountWidth-1:0]    freeSlots;
  logic [LaneCntWidth-1:0]           laneCount;
  logic [$clog2(CommitWidth+1)-1:0]  commitCount;

  // Popcounts of the fetch lanes and the commit pulses
  always_comb
  begin
    laneCount = '0;
    for (int i = 0; i < FetchWidth; i++)
    begin
      laneCount = laneCount + LaneCntWidth'(ctrlVect_i[i]);
    end
    commitCount = '0;
    for (int i = 0; i < CommitWidth; i++)
    begin
      commitCount = commitCount + ($clog2(CommitWidth+1))'(commitCti_i[i]);
    end
  end

  assign freeSlots     = ctiqPkg::CountWidth'(ctiqPkg::QueueDepth) - count;
  assign full_o        = ctiqPkg::CountWidth'(laneCount) > freeSlots;
  assign accept_o      = fs1Ready_i & ~stall_i & ~full_o & ~recoverFlag_i;
  assign updateEn_o    = headCommitted_i & (count != '0) & ~recoverFlag_i;
  assign commitPtrNext = commitPtr + ctiqPkg::ctiId_t'(commitCount);

  always_comb
  begin
    countNext = count;
    if (accept_o)
    begin
      countNext = countNext + ctiqPkg::CountWidth'(laneCount);
    end
    if (updateEn_o)
    begin
      countNext = countNext - 1'b1;
    end
    // Everything past the last committed entry is squashed on recovery
    if (commitPtrNext >= headPtr)
    begin
      countRecover = ctiqPkg::CountWidth'(commitPtrNext - headPtr);
    end
    else
    begin
      countRecover = ctiqPkg::CountWidth'(ctiqPkg::QueueDepth)
                     - ctiqPkg::CountWidth'(headPtr)
                     + ctiqPkg::CountWidth'(commitPtrNext);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      tailPtr   <= '0;
      headPtr   <= '0;
      commitPtr <= '0;
      count     <= '0;
    end
    else
    begin
      commitPtr <= commitPtrNext;
      if (updateEn_o)
      begin
        headPtr <= headPtr + 1'b1;
      end
      if (recoverFlag_i)
      begin
        tailPtr <= commitPtrNext;
        count   <= countRecover;
      end
      else
      begin
        if (accept_o)
        begin
          tailPtr <= tailPtr + ctiqPkg::ctiId_t'(laneCount);
        end
        count <= countNext;
      end
    end
  end

  assign tailPtr_o     = tailPtr;
  assign headPtr_o     = headPtr;
  assign commitPtr_o   = commitPtr;
  assign commitCount_o = commitCount;

endmodule

// File: hw/ctrlQueue.sv
`timescale 1ns/1ps

module ctrlQueue #(
  parameter int FetchWidth  = 4,
  parameter int CommitWidth = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fs1Ready_i,
  input  logic                  stall_i,
  input  logic                  recoverFlag_i,
  input  logic [FetchWidth-1:0] ctrlVect_i,
  input  ctiqPkg::predCounter_t predCounter_i [0:FetchWidth-1],
  output ctiqPkg::ctiId_t       ctiId_o [0:FetchWidth-1],
  input  ctiqPkg::exeResolve_t  exeResolve_i,
  input  logic [CommitWidth-1:0] commitCti_i,
  output ctiqPkg::predUpdate_t  predUpdate_o,
  output logic                  ctiQueueFull_o,
  output logic                  ctiqRamReady_o
);

  ctiqPkg::ctiId_t                  tailPtr;
  ctiqPkg::ctiId_t                  headPtr;
  ctiqPkg::ctiId_t                  commitPtr;
  logic [$clog2(CommitWidth+1)-1:0] commitCount;
  logic                             accept;
  logic                             updateEn;
  logic                             headCommitted;
  logic                             initWe;
  ctiqPkg::ctiId_t                  initAddr;
  ctiqPkg::ctiEntry_t               headEntry;
  ctiqPkg::predCounter_t            headCounter;
  logic [FetchWidth-1:0]            counterWe;

  // Counters are stored only for a bundle that is actually taken
  assign counterWe = ctrlVect_i & {FetchWidth{accept}};

  ctiqInitFsm initFsm_i (
    .clk        (clk),
    .reset      (reset),
    .initWe_o   (initWe),
    .initAddr_o (initAddr),
    .ramReady_o (ctiqRamReady_o)
  );

  ctiqPointers #(
    .FetchWidth  (FetchWidth),
    .CommitWidth (CommitWidth)
  ) pointers_i (
    .clk             (clk),
    .reset           (reset),
    .ctrlVect_i      (ctrlVect_i),
    .fs1Ready_i      (fs1Ready_i),
    .stall_i         (stall_i),
    .recoverFlag_i   (recoverFlag_i),
    .commitCti_i     (commitCti_i),
    .headCommitted_i (headCommitted),
    .tailPtr_o       (tailPtr),
    .headPtr_o       (headPtr),
    .commitPtr_o     (commitPtr),
    .commitCount_o   (commitCount),
    .accept_o        (accept),
    .updateEn_o      (updateEn),
    .full_o          (ctiQueueFull_o)
  );

  ctiqIdAssign #(
    .FetchWidth (FetchWidth)
  ) idAssign_i (
    .ctrlVect_i (ctrlVect_i),
    .tailPtr_i  (tailPtr),
    .ctiId_o    (ctiId_o)
  );

  ctiqEntryRam #(
    .FetchWidth (FetchWidth)
  ) entryRam_i (
    .clk           (clk),
    .exeResolve_i  (exeResolve_i),
    .initWe_i      (initWe),
    .initAddr_i    (initAddr),
    .counterWe_i   (counterWe),
    .ctiId_i       (ctiId_o),
    .predCounter_i (predCounter_i),
    .headPtr_i     (headPtr),
    .headEntry_o   (headEntry),
    .headCounter_o (headCounter)
  );

  ctiqCommitBits #(
    .CommitWidth (CommitWidth)
  ) commitBits_i (
    .clk             (clk),
    .reset           (reset),
    .commitPtr_i     (commitPtr),
    .commitCount_i   (commitCount),
    .headPtr_i       (headPtr),
    .clearHead_i     (updateEn),
    .headCommitted_o (headCommitted)
  );

  assign predUpdate_o = '{entry: headEntry, counter: headCounter, en: updateEn};

endmodule

// File: run.sh
#!/bin/sh
# Build and run the control queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module ctrlQueueTb -f ctrlQueue.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VctrlQueueTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
exit 0

// File: tests/ctrlQueueTb.sv
`timescale 1ns/1ps

module ctrlQueueTb;

  localparam int FetchWidth  = 4;
  localparam int CommitWidth = 4;
  localparam int Depth       = ctiqPkg::QueueDepth;
  // About 600 cycles of tests
  localparam int CycleLimit  = 2000;

  logic                   clk;
  logic                   reset;
  logic                   fs1Ready;
  logic                   stall;
  logic                   recoverFlag;
  logic [FetchWidth-1:0]  ctrlVect;
  ctiqPkg::predCounter_t  predCounter [0:FetchWidth-1];
  ctiqPkg::ctiId_t        ctiId [0:FetchWidth-1];
  ctiqPkg::exeResolve_t   exeResolve;
  logic [CommitWidth-1:0] commitCti;
  ctiqPkg::predUpdate_t   predUpdate;
  logic                   queueFull;
  logic                   ramReady;

  int errors;
  int assertFails;
  int seed;
  int cycles;
  int readyWait;

  // Reference model of the pointers and the entry contents
  ctiqPkg::ctiId_t       tail;
  ctiqPkg::ctiId_t       head;
  ctiqPkg::ctiId_t       commitPtr;
  ctiqPkg::ctiId_t       resolvePtr;
  int                    occupancy;
  int                    unresolved;
  int                    resolved;
  int                    pending;
  ctiqPkg::ctiEntry_t    modelEntry [0:Depth-1];
  ctiqPkg::predCounter_t modelCounter [0:Depth-1];

  ctrlQueue dut_i (
    .clk            (clk),
    .reset          (reset),
    .fs1Ready_i     (fs1Ready),
    .stall_i        (stall),
    .recoverFlag_i  (recoverFlag),
    .ctrlVect_i     (ctrlVect),
    .predCounter_i  (predCounter),
    .ctiId_o        (ctiId),
    .exeResolve_i   (exeResolve),
    .commitCti_i    (commitCti),
    .predUpdate_o   (predUpdate),
    .ctiQueueFull_o (queueFull),
    .ctiqRamReady_o (ramReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    cycles = 0;
    while (cycles < CycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not complete", CycleLimit);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic noteMismatch(input string name, input logic [69:0] expVal,
                              input logic [69:0] actVal);
    errors++;
    $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expVal, actVal);
  endtask

  // One clock of stimulus, checked at the falling edge, then the model steps
  task automatic runCycle(input logic [FetchWidth-1:0] lanes, input logic fetchReady,
                          input logic stallIn, input logic recover);
    int              laneCnt;
    int              commitCnt;
    int              offset;
    logic            resolving;
    logic            expFull;
    logic            expEn;
    logic            accepted;
    ctiqPkg::ctiId_t expId;
    ctrlVect    = lanes;
    fs1Ready    = fetchReady;
    stall       = stallIn;
    recoverFlag = recover;
    for (int k = 0; k < FetchWidth; k++)
    begin
      predCounter[k] = ctiqPkg::predCounter_t'($random(seed));
    end
    // Execute resolves the oldest unresolved entry, one per cycle
    resolving  = (unresolved > 0);
    exeResolve = '0;
    if (resolving)
    begin
      exeResolve.pc       = $random(seed);
      exeResolve.npc      = $random(seed);
      exeResolve.ctrlType = ctiqPkg::branchType_t'($random(seed) & 3);
      exeResolve.dir      = $random(seed) & 1;
      exeResolve.ctiId    = resolvePtr;
      exeResolve.valid    = 1'b1;
      modelEntry[resolvePtr] = '{pc: exeResolve.pc, npc: exeResolve.npc,
                                 ctrlType: exeResolve.ctrlType, dir: exeResolve.dir};
    end
    commitCnt = $random(seed) & 7;
    if (commitCnt > resolved)
    begin
      commitCnt = resolved;
    end
    if (commitCnt > CommitWidth)
    begin
      commitCnt = CommitWidth;
    end
    commitCti = CommitWidth'((1 << commitCnt) - 1);

    @(negedge clk);
    laneCnt  = $countones(lanes);
    expFull  = laneCnt > Depth - occupancy;
    expEn    = (pending > 0) && (occupancy != 0) && !recover;
    accepted = fetchReady && !stallIn && !expFull && !recover;
    assert (ramReady) else noteMismatch("ctiqRamReady_o", 1, ramReady);
    assert (queueFull == expFull) else noteMismatch("ctiQueueFull_o", expFull, queueFull);
    offset = 0;
    for (int k = 0; k < FetchWidth; k++)
    begin
      expId = '0;
      if (lanes[k])
      begin
        expId = ctiqPkg::ctiId_t'(tail + offset);
        offset++;
        if (accepted)
        begin
          modelCounter[expId] = predCounter[k];
        end
      end
      assert (ctiId[k] == expId)
        else noteMismatch($sformatf("ctiId_o[%0d]", k), expId, ctiId[k]);
    end
    assert (predUpdate.en == expEn) else noteMismatch("predUpdate_o.en", expEn, predUpdate.en);
    if (expEn && predUpdate.en)
    begin
      assert (predUpdate.entry == modelEntry[head])
        else noteMismatch("predUpdate_o.entry", modelEntry[head], predUpdate.entry);
      assert (predUpdate.counter == modelCounter[head])
        else noteMismatch("predUpdate_o.counter", modelCounter[head], predUpdate.counter);
    end

    if (accepted)
    begin
      tail       = ctiqPkg::ctiId_t'(tail + laneCnt);
      occupancy  = occupancy + laneCnt;
      unresolved = unresolved + laneCnt;
    end
    if (resolving)
    begin
      unresolved--;
      resolved++;
      resolvePtr = resolvePtr + 1'b1;
    end
    resolved  = resolved - commitCnt;
    pending   = pending + commitCnt;
    commitPtr = ctiqPkg::ctiId_t'(commitPtr + commitCnt);
    if (expEn)
    begin
      head = head + 1'b1;
      occupancy--;
      pending--;
    end
    // Recovery squashes everything younger than the last commit
    if (recover)
    begin
      tail       = commitPtr;
      resolvePtr = commitPtr;
      occupancy  = pending;
      unresolved = 0;
      resolved   = 0;
    end
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    seed        = 65;
    errors      = 0;
    assertFails = 0;
    reset       = 1'b1;
    fs1Ready    = 1'b0;
    stall       = 1'b0;
    recoverFlag = 1'b0;
    ctrlVect    = '0;
    exeResolve  = '0;
    commitCti   = '0;
    for (int k = 0; k < FetchWidth; k++)
    begin
      predCounter[k] = '0;
    end
    tail       = '0;
    head       = '0;
    commitPtr  = '0;
    resolvePtr = '0;
    occupancy  = 0;
    unresolved = 0;
    resolved   = 0;
    pending    = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    assert (!ramReady) else noteMismatch("ctiqRamReady_o", 0, ramReady);
    readyWait = 0;
    while (!ramReady)
    begin
      @(posedge clk);
      #1;
      readyWait++;
    end
    assert (readyWait == Depth + 1)
      else begin
        errors++;
        $display("RAM clear took %0d cycles instead of %0d", readyWait, Depth + 1);
      end

    // Random traffic with enough fetch to hit the full flag, plus stalls and recoveries
    repeat (500)
    begin
      runCycle($random(seed), ($random(seed) & 7) != 0, ($random(seed) & 7) == 0,
               ($random(seed) & 31) == 0);
    end
    // Fetch stops so every entry can commit and drain
    while (occupancy != 0)
    begin
      runCycle('0, 1'b0, 1'b0, 1'b0);
    end
    repeat (3) runCycle('0, 1'b1, 1'b0, 1'b0);

    assertFails = dut_i.sva_i.failCount;
    $display("Checks finished with %0d mismatches and %0d assertion failures",
             errors, assertFails);
    if (errors == 0 && assertFails == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/ctrlQueue_sva.sv
`timescale 1ns/1ps

module ctrlQueueSva #(
  parameter int FetchWidth  = 4,
  parameter int CommitWidth = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fs1Ready_i,
  input  logic                   stall_i,
  input  logic                   recoverFlag_i,
  input  logic [FetchWidth-1:0]  ctrlVect_i,
  input  logic [CommitWidth-1:0] commitCti_i,
  input  ctiqPkg::predUpdate_t   predUpdate_o,
  input  logic                   ctiQueueFull_o,
  input  logic                   ctiqRamReady_o
);

  int   laneCount;
  int   commitCount;
  int   occupancy;
  int   pending;
  int   failCount = 0;
  logic bundleTaken;
  logic drainDue;

  assign laneCount   = $countones(ctrlVect_i);
  assign commitCount = $countones(commitCti_i);
  // A bundle is taken only when it fits in the free slots of the shadow queue
  assign bundleTaken = fs1Ready_i & ~stall_i & ~recoverFlag_i
                       & (laneCount <= ctiqPkg::QueueDepth - occupancy);
  assign drainDue    = (pending != 0) & (occupancy != 0) & ~recoverFlag_i;

  // Shadow occupancy and the committed entries still waiting to drain
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      occupancy <= 0;
      pending   <= 0;
    end
    else if (recoverFlag_i)
    begin
      occupancy <= pending + commitCount;
      pending   <= pending + commitCount;
    end
    else
    begin
      occupancy <= occupancy + (bundleTaken ? laneCount : 0) - int'(drainDue);
      pending   <= pending + commitCount - int'(drainDue);
    end
  end

  ramReadyHolds: assert property (@(posedge clk) disable iff (reset)
    ctiqRamReady_o |=> ctiqRamReady_o)
    else
    begin
      failCount++;
      $error("ctiqRamReady_o fell after the RAM clear had finished");
    end

  noUpdateWhenEmpty: assert property (@(posedge clk) disable iff (reset)
    predUpdate_o.en |-> occupancy != 0)
    else
    begin
      failCount++;
      $error("Update sent while the queue is empty");
    end

  noUpdateBeforeCommit: assert property (@(posedge clk) disable iff (reset)
    predUpdate_o.en |-> pending != 0)
    else
    begin
      failCount++;
      $error("Update sent for an entry that was never committed");
    end

  noUpdateDuringClear: assert property (@(posedge clk) disable iff (reset)
    !ctiqRamReady_o |-> !predUpdate_o.en)
    else
    begin
      failCount++;
      $error("Update sent while the entry RAM is still being cleared");
    end

  fullMeansNoRoom: assert property (@(posedge clk) disable iff (reset)
    ctiQueueFull_o |-> (laneCount + occupancy > ctiqPkg::QueueDepth))
    else
    begin
      failCount++;
      $error("Full flag raised although the bundle fits");
    end

endmodule

bind ctrlQueue ctrlQueueSva #(
  .FetchWidth  (FetchWidth),
  .CommitWidth (CommitWidth)
) sva_i (
  .clk            (clk),
  .reset          (reset),
  .fs1Ready_i     (fs1Ready_i),
  .stall_i        (stall_i),
  .recoverFlag_i  (recoverFlag_i),
  .ctrlVect_i     (ctrlVect_i),
  .commitCti_i    (commitCti_i),
  .predUpdate_o   (predUpdate_o),
  .ctiQueueFull_o (ctiQueueFull_o),
  .ctiqRamReady_o (ctiqRamReady_o)
);
